/* src/lspcPkg.sv */
`default_nettype none

package lspcPkg;

	// ========================================
	// Widths and frame geometry
	// ========================================

	// CPU bus and VRAM word width
	localparam int WORD_BITS = 16;
	// Low address bits that index the on-chip VRAM
	localparam int VRAM_INDEX_BITS = 8;
	// Raster lines in one frame
	localparam int LINES_PER_FRAME = 264;
	localparam int RASTER_BITS = 9;
	// Auto-animation tile count and speed
	localparam int AA_BITS = 3;
	localparam int AA_SPEED_BITS = 8;

	// ========================================
	// Register select codes
	// ========================================

	localparam logic [2:0] REG_VRAMADDR = 3'd0;
	localparam logic [2:0] REG_VRAMRW = 3'd1;
	localparam logic [2:0] REG_VRAMMOD = 3'd2;
	localparam logic [2:0] REG_LSPCMODE = 3'd3;

	// Decoded CPU access, one per cycle
	typedef struct packed {
		logic valid;
		logic isWrite;
		logic [2:0] regSel;
		logic [WORD_BITS-1:0] data;
	} lspcCmd;

	// Execute stage output toward read-back
	typedef struct packed {
		logic readValid;
		logic [2:0] regSel;
		logic [WORD_BITS-1:0] vramWord;
	} lspcResult;

	// LSPCMODE word, CPU write side
	typedef struct packed {
		logic [AA_SPEED_BITS-1:0] aaSpeed;
		logic [WORD_BITS-AA_SPEED_BITS-1:0] unused;
	} lspcModeWr;

	// LSPCMODE word, CPU read side
	typedef struct packed {
		logic [RASTER_BITS-1:0] rasterLine;
		logic [WORD_BITS-RASTER_BITS-AA_BITS-1:0] zero;
		logic [AA_BITS-1:0] aaCount;
	} lspcModeRd;

	// Same address, different meaning per direction
	typedef union packed {
		lspcModeWr wr;
		lspcModeRd rd;
	} lspcModeWord;

endpackage

`default_nettype wire

/* src/lspcRegDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcRegDecode (
	input  logic                          CLK_24M,
	input  logic                          T73A_OUT,
	input  logic                          cpuWrite,
	input  logic                          cpuRead,
	input  logic [2:0]                    regSel,
	input  logic [lspcPkg::WORD_BITS-1:0] cpuDataIn,
	output lspcPkg::lspcCmd               cmd
);
	import lspcPkg::*;

	logic selUsed;
	logic cmdValid;
	logic cmdIsWrite;
	logic [2:0] cmdSel;
	logic [WORD_BITS-1:0] cmdData;

	// Only codes 0 to 3 have a register behind them
	assign selUsed = (regSel <= REG_LSPCMODE);

	// ========================================
	// Strobe capture
	// ========================================

	// Control bits, cleared by reset
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			cmdValid <= 1'b0;
			cmdIsWrite <= 1'b0;
		end
		else
		begin
			// Writes to dead codes vanish here
			// Reads still go through so they come back as zero
			cmdValid <= (cpuWrite && selUsed) || cpuRead;
			cmdIsWrite <= cpuWrite;
		end
	end

	// Select and data follow the bus every cycle
	always_ff @(posedge CLK_24M)
	begin
		cmdSel <= regSel;
		cmdData <= cpuDataIn;
	end

	// Pack into the command word
	always_comb
	begin
		cmd.valid = cmdValid;
		cmd.isWrite = cmdIsWrite;
		cmd.regSel = cmdSel;
		cmd.data = cmdData;
	end

endmodule

`default_nettype wire

/* src/vramPort.sv */
`timescale 1ns/1ps
`default_nettype none

module vramPort (
	input  logic                              CLK_24M,
	input  logic                              T73A_OUT,
	input  lspcPkg::lspcCmd                   cmd,
	output lspcPkg::lspcResult                result,
	output logic [lspcPkg::WORD_BITS-1:0]     vramMod,
	output logic [lspcPkg::AA_SPEED_BITS-1:0] aaSpeed
);
	import lspcPkg::*;

	logic [WORD_BITS-1:0] vramAddr;
	logic [WORD_BITS-1:0] vramMem [0:(1<<VRAM_INDEX_BITS)-1];
	logic [VRAM_INDEX_BITS-1:0] vramIndex;
	logic wrStrobe;
	logic rdStrobe;
	lspcModeWord modeIn;
	logic resValid;
	logic [2:0] resSel;
	logic [WORD_BITS-1:0] resWord;

	// Array only sees the low address bits
	assign vramIndex = vramAddr[VRAM_INDEX_BITS-1:0];
	assign wrStrobe = cmd.valid && cmd.isWrite;
	assign rdStrobe = cmd.valid && !cmd.isWrite;
	// Incoming word seen as LSPCMODE write
	assign modeIn = cmd.data;

	// ========================================
	// Address, modulo and mode registers
	// ========================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			vramAddr <= '0;
			vramMod <= '0;
			aaSpeed <= '0;
		end
		else if (wrStrobe)
		begin
			case (cmd.regSel)
				REG_VRAMADDR: vramAddr <= cmd.data;
				// Post-increment after each data port write
				REG_VRAMRW: vramAddr <= vramAddr + vramMod;
				REG_VRAMMOD: vramMod <= cmd.data;
				REG_LSPCMODE: aaSpeed <= modeIn.wr.aaSpeed;
				default: ;
			endcase
		end
	end

	// ========================================
	// VRAM array and result stage
	// ========================================

	// Store at the address before the increment
	always_ff @(posedge CLK_24M)
	begin
		if (wrStrobe && (cmd.regSel == REG_VRAMRW))
			vramMem[vramIndex] <= cmd.data;
	end

	// Read strobe for result
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			resValid <= 1'b0;
		else
			resValid <= rdStrobe;
	end

	// Select and word ride along
	always_ff @(posedge CLK_24M)
	begin
		resSel <= cmd.regSel;
		resWord <= vramMem[vramIndex];
	end

	// Pack into the result word
	always_comb
	begin
		result.readValid = resValid;
		result.regSel = resSel;
		result.vramWord = resWord;
	end

endmodule

`default_nettype wire

/* src/rasterAnimTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module rasterAnimTimer (
	input  logic                              CLK_24M,
	input  logic                              T73A_OUT,
	input  logic                              lineTick,
	input  logic [lspcPkg::AA_SPEED_BITS-1:0] aaSpeed,
	output logic [lspcPkg::RASTER_BITS-1:0]   rasterLine,
	output logic [lspcPkg::AA_BITS-1:0]       aaCount
);
	import lspcPkg::*;

	logic [AA_SPEED_BITS-1:0] frameDiv;
	logic lastLine;
	logic frameEnd;
	logic divHit;

	// Last raster line of the frame
	assign lastLine = (rasterLine == RASTER_BITS'(LINES_PER_FRAME - 1));
	// Wrap happens on this tick
	assign frameEnd = lineTick && lastLine;
	// Divider has counted speed+1 frames
	assign divHit = (frameDiv == aaSpeed);

	// ========================================
	// Line, frame and animation counters
	// ========================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			rasterLine <= '0;
			frameDiv <= '0;
			aaCount <= '0;
		end
		else
		begin
			// Line counter, wraps once per frame
			if (lineTick)
				rasterLine <= lastLine ? '0 : rasterLine + 1'b1;
			// Frame divider against the animation speed
			if (frameEnd)
			begin
				if (divHit)
				begin
					frameDiv <= '0;
					// Tile count rolls over by width
					aaCount <= aaCount + 1'b1;
				end
				else
					frameDiv <= frameDiv + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/lspcReadBack.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcReadBack (
	input  logic                            CLK_24M,
	input  logic                            T73A_OUT,
	input  lspcPkg::lspcResult              result,
	input  logic [lspcPkg::WORD_BITS-1:0]   vramMod,
	input  logic [lspcPkg::RASTER_BITS-1:0] rasterLine,
	input  logic [lspcPkg::AA_BITS-1:0]     aaCount,
	output logic [lspcPkg::WORD_BITS-1:0]   cpuDataOut,
	output logic                            readValid
);
	import lspcPkg::*;

	lspcModeWord modeOut;
	logic [WORD_BITS-1:0] readMux;

	// LSPCMODE as the CPU sees it
	always_comb
	begin
		modeOut.rd.rasterLine = rasterLine;
		modeOut.rd.zero = '0;
		modeOut.rd.aaCount = aaCount;
	end

	// ========================================
	// Read data select
	// ========================================

	always_comb
	begin
		case (result.regSel)
			// Both VRAM codes return the array word
			REG_VRAMADDR, REG_VRAMRW: readMux = result.vramWord;
			REG_VRAMMOD: readMux = vramMod;
			REG_LSPCMODE: readMux = modeOut;
			// Unused codes read as zero
			default: readMux = '0;
		endcase
	end

	// Output strobe
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			readValid <= 1'b0;
		else
			readValid <= result.readValid;
	end

	// Data only matters while readValid is high
	always_ff @(posedge CLK_24M)
	begin
		cpuDataOut <= readMux;
	end

endmodule

`default_nettype wire

/* src/lspcTop.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcTop (
	input  logic                          CLK_24M,
	input  logic                          T73A_OUT,
	input  logic                          cpuWrite,
	input  logic                          cpuRead,
	input  logic [2:0]                    regSel,
	input  logic [lspcPkg::WORD_BITS-1:0] cpuDataIn,
	input  logic                          lineTick,
	output logic [lspcPkg::WORD_BITS-1:0] cpuDataOut,
	output logic                          readValid
);
	import lspcPkg::*;

	// Stage to stage wiring
	lspcCmd cmd;
	lspcResult result;
	logic [WORD_BITS-1:0] vramMod;
	logic [AA_SPEED_BITS-1:0] aaSpeed;
	logic [RASTER_BITS-1:0] rasterLine;
	logic [AA_BITS-1:0] aaCount;

	// ========================================
	// Decode, execute, result
	// ========================================

	lspcRegDecode uDecode (
		.CLK_24M   (CLK_24M),
		.T73A_OUT  (T73A_OUT),
		.cpuWrite  (cpuWrite),
		.cpuRead   (cpuRead),
		.regSel    (regSel),
		.cpuDataIn (cpuDataIn),
		.cmd       (cmd)
	);

	vramPort uVram (
		.CLK_24M  (CLK_24M),
		.T73A_OUT (T73A_OUT),
		.cmd      (cmd),
		.result   (result),
		.vramMod  (vramMod),
		.aaSpeed  (aaSpeed)
	);

	// Free running raster and animation
	rasterAnimTimer uTimer (
		.CLK_24M    (CLK_24M),
		.T73A_OUT   (T73A_OUT),
		.lineTick   (lineTick),
		.aaSpeed    (aaSpeed),
		.rasterLine (rasterLine),
		.aaCount    (aaCount)
	);

	lspcReadBack uReadBack (
		.CLK_24M    (CLK_24M),
		.T73A_OUT   (T73A_OUT),
		.result     (result),
		.vramMod    (vramMod),
		.rasterLine (rasterLine),
		.aaCount    (aaCount),
		.cpuDataOut (cpuDataOut),
		.readValid  (readValid)
	);

endmodule

`default_nettype wire

/* dv/clkGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clkGen (
	output logic CLK_24M,
	output logic T73A_OUT
);

	// 10 ns period, first rising edge at 5 ns
	initial
	begin
		CLK_24M = 1'b0;
		forever #5 CLK_24M = ~CLK_24M;
	end

	// Reset low across the first two rising edges
	initial
	begin
		T73A_OUT <= 1'b0;
		repeat (2) @(posedge CLK_24M);
		@(negedge CLK_24M);
		// Goes high once the falling edge processes have run
		T73A_OUT <= 1'b1;
	end

endmodule

`default_nettype wire

/* dv/lspcTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcTb;
	import lspcPkg::*;

	logic CLK_24M;
	logic T73A_OUT;
	logic cpuWrite;
	logic cpuRead;
	logic [2:0] regSel;
	logic [WORD_BITS-1:0] cpuDataIn;
	logic lineTick;
	logic [WORD_BITS-1:0] cpuDataOut;
	logic readValid;

	// Reference model state
	logic [WORD_BITS-1:0] modelMem [0:255];
	logic [WORD_BITS-1:0] modelAddr;
	logic [WORD_BITS-1:0] modelMod;
	logic [AA_SPEED_BITS-1:0] modelSpeed;
	logic [RASTER_BITS-1:0] modelLine;
	logic [AA_SPEED_BITS-1:0] modelDiv;
	logic [AA_BITS-1:0] modelAa;
	integer seed;
	int mismatchCount;
	int otherErrors;
	int waitCycles;

	clkGen uClk (.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT));

	lspcTop dut (
		.CLK_24M    (CLK_24M),
		.T73A_OUT   (T73A_OUT),
		.cpuWrite   (cpuWrite),
		.cpuRead    (cpuRead),
		.regSel     (regSel),
		.cpuDataIn  (cpuDataIn),
		.lineTick   (lineTick),
		.cpuDataOut (cpuDataOut),
		.readValid  (readValid)
	);

	// ========================================
	// Bus helpers and model
	// ========================================

	task automatic expectWord(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			mismatchCount++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// One write strobe, model follows the register rules
	task automatic writeReg(input logic [2:0] sel, input logic [15:0] data);
		cpuWrite = 1'b1;
		regSel = sel;
		cpuDataIn = data;
		case (sel)
			REG_VRAMADDR: modelAddr = data;
			REG_VRAMRW:
			begin
				// Store first, then step by the modulo
				modelMem[modelAddr[7:0]] = data;
				modelAddr = modelAddr + modelMod;
			end
			REG_VRAMMOD: modelMod = data;
			REG_LSPCMODE: modelSpeed = data[15:8];
			default: ;
		endcase
		@(negedge CLK_24M);
		cpuWrite = 1'b0;
	endtask

	// Read strobe, then wait for readValid
	task automatic readReg(input logic [2:0] sel, output logic [15:0] data,
		output int latency);
		int cycles;
		cycles = 0;
		cpuRead = 1'b1;
		regSel = sel;
		do
		begin
			@(negedge CLK_24M);
			cpuRead = 1'b0;
			cycles++;
		end
		while (!readValid && cycles < 20);
		// Sampling edge lies half a cycle after the strobe
		latency = cycles - 1;
		data = cpuDataOut;
		assert (readValid)
		else
		begin
			otherErrors++;
			$display("timeout: no readValid within 20 cycles of a read of select %0d", sel);
		end
	endtask

	task automatic expectRead(input logic [2:0] sel, input logic [15:0] exp,
		input string name);
		logic [15:0] data;
		int latency;
		readReg(sel, data, latency);
		expectWord(name, data, exp);
	endtask

	// lineTick high for n cycles
	task automatic pulseLines(input int n);
		for (int i = 0; i < n; i++)
		begin
			lineTick = 1'b1;
			if (modelLine == 9'd263)
			begin
				modelLine = '0;
				// Frame end, divider against speed
				if (modelDiv == modelSpeed)
				begin
					modelDiv = '0;
					modelAa = modelAa + 3'd1;
				end
				else
					modelDiv = modelDiv + 8'd1;
			end
			else
				modelLine = modelLine + 9'd1;
			@(negedge CLK_24M);
		end
		lineTick = 1'b0;
	endtask

	// LSPCMODE read view from the model
	function automatic logic [15:0] modeReadWord();
		return {modelLine, 4'b0000, modelAa};
	endfunction

	// ========================================
	// Directed tests
	// ========================================

	task automatic resetReadsZero();
		expectRead(REG_VRAMMOD, 16'h0000, "VRAMMOD after reset");
		expectRead(REG_LSPCMODE, 16'h0000, "LSPCMODE after reset");
	endtask

	// Modulo 1, eight random words, readback one address at a time
	task automatic sequentialVramWords();
		writeReg(REG_VRAMADDR, 16'h2140);
		writeReg(REG_VRAMMOD, 16'h0001);
		for (int i = 0; i < 8; i++)
			writeReg(REG_VRAMRW, 16'($random(seed)));
		for (int i = 0; i < 8; i++)
		begin
			writeReg(REG_VRAMADDR, 16'h2140 + 16'(i));
			expectRead(REG_VRAMRW, modelMem[8'h40 + 8'(i)], "VRAMRW sequential");
		end
	endtask

	task automatic moduloStride();
		logic [15:0] word;
		writeReg(REG_VRAMMOD, 16'h0003);
		// New modulo visible on the very next access
		expectRead(REG_VRAMMOD, 16'h0003, "VRAMMOD");
		writeReg(REG_VRAMADDR, 16'h0010);
		for (int i = 0; i < 4; i++)
			writeReg(REG_VRAMRW, 16'($random(seed)));
		for (int i = 0; i < 4; i++)
		begin
			writeReg(REG_VRAMADDR, 16'h0010 + 16'(3 * i));
			expectRead(REG_VRAMRW, modelMem[8'h10 + 8'(3 * i)], "VRAMRW modulo 3");
		end
		// Modulo 0 holds the address, read strobed right behind the write
		writeReg(REG_VRAMMOD, 16'h0000);
		writeReg(REG_VRAMADDR, 16'h0080);
		word = 16'($random(seed));
		writeReg(REG_VRAMRW, word);
		expectRead(REG_VRAMRW, word, "VRAMRW read after write");
	endtask

	task automatic rasterLineCount();
		pulseLines(100);
		expectRead(REG_LSPCMODE, modeReadWord(), "LSPCMODE raster 100");
		// 300 lines total, one wrap
		pulseLines(200);
		expectRead(REG_LSPCMODE, modeReadWord(), "LSPCMODE raster wrap");
	endtask

	task automatic autoAnimSteps();
		logic [15:0] data;
		int latency;
		logic [2:0] startAa;
		logic [2:0] aaStep;
		startAa = modelAa;
		// Speed 1 in the high byte, low byte is ignored
		writeReg(REG_LSPCMODE, 16'h01A5);
		pulseLines(4 * LINES_PER_FRAME);
		readReg(REG_LSPCMODE, data, latency);
		expectWord("LSPCMODE after 4 frames", data, modeReadWord());
		aaStep = data[2:0] - startAa;
		expectWord("aaCount step", 16'(aaStep), 16'd2);
	endtask

	task automatic unusedSelectRead();
		logic [15:0] data;
		int latency;
		// Dead code write leaves the modulo and the data port alone
		writeReg(3'd5, 16'hBEEF);
		expectRead(REG_VRAMMOD, modelMod, "VRAMMOD after code 5 write");
		expectRead(REG_VRAMRW, modelMem[modelAddr[7:0]], "VRAMRW after code 5 write");
		readReg(3'd5, data, latency);
		expectWord("code 5 read", data, 16'h0000);
		expectWord("readValid latency", 16'(latency), 16'd2);
		@(negedge CLK_24M);
		expectWord("readValid one cycle later", 16'(readValid), 16'h0000);
	endtask

	initial
	begin
		cpuWrite = 1'b0;
		cpuRead = 1'b0;
		regSel = 3'd0;
		cpuDataIn = '0;
		lineTick = 1'b0;
		seed = 17;
		mismatchCount = 0;
		otherErrors = 0;
		modelAddr = '0;
		modelMod = '0;
		modelSpeed = '0;
		modelLine = '0;
		modelDiv = '0;
		modelAa = '0;
		waitCycles = 0;
		while (T73A_OUT !== 1'b1 && waitCycles < 10)
		begin
			@(negedge CLK_24M);
			waitCycles++;
		end
		assert (T73A_OUT === 1'b1)
		else
		begin
			otherErrors++;
			$display("reset was never released");
		end
		resetReadsZero();
		sequentialVramWords();
		moduloStride();
		rasterLineCount();
		autoAnimSteps();
		unusedSelectRead();
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
src/lspcPkg.sv
src/lspcRegDecode.sv
src/vramPort.sv
src/rasterAnimTimer.sv
src/lspcReadBack.sv
src/lspcTop.sv
dv/clkGen.sv
dv/lspcTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

# Build the testbench around the LSPC register block
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module lspcTb -f sim.f --Mdir obj_dir -o lspcSim

# Run and keep the log
./obj_dir/lspcSim | tee sim.log

# The log decides the result
if grep -q "TESTS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
